//--- design/isa_pkg.sv
package isa_pkg;

    // data and address word, bit 0 is the msb
    typedef logic [0:31] word_t;
    typedef logic [0:4]  reg_idx_t;

    // primary opcodes
    typedef enum logic [0:5] {
        op_rtype = 6'h00,
        op_beqz  = 6'h04,
        op_bnez  = 6'h05,
        op_addi  = 6'h08,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_t;

    // r-type function codes
    typedef enum logic [0:5] {
        func_sll = 6'h04,
        func_srl = 6'h06,
        func_add = 6'h20,
        func_sub = 6'h22,
        func_and = 6'h24,
        func_or  = 6'h25,
        func_xor = 6'h26,
        func_slt = 6'h2a
    } func_t;

    typedef enum logic [0:2] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl
    } alu_op_t;

    // field start bits, counted from the msb
    localparam int opcode_pos = 0;
    localparam int rs1_pos    = 6;
    localparam int rs2_pos    = 11;
    localparam int rd_pos     = 16;
    localparam int func_pos   = 26;
    localparam int imm16_pos  = 16;
    // i-type writes the register named in the rs2 field
    localparam int itype_rd_pos = rs2_pos;

    // one alu result for the execute stage
    function automatic word_t alu_compute(input alu_op_t op, input word_t a, input word_t b);
        case (op)
            alu_add: return a + b;
            alu_sub: return a - b;
            alu_and: return a & b;
            alu_or:  return a | b;
            alu_xor: return a ^ b;
            // signed compare, result is 0 or 1
            alu_slt: return {31'b0, $signed(a) < $signed(b)};
            // shift amount from the low five bits
            alu_sll: return a << b[27:31];
            alu_srl: return a >> b[27:31];
            default: return a + b;
        endcase
    endfunction

endpackage

//--- design/pipe_pkg.sv
package pipe_pkg;

    // decoded control, all zero means bubble
    typedef struct packed {
        logic              reg_write;
        logic              mem_to_reg;
        logic              mem_write;
        logic              alu_src_imm;
        logic              branch;
        logic              branch_on_zero;
        isa_pkg::alu_op_t  alu_op;
    } ctrl_t;

    typedef struct packed {
        logic           valid;
        isa_pkg::word_t pc_plus4;
        isa_pkg::word_t instr;
    } if_id_t;

    typedef struct packed {
        logic              valid;
        ctrl_t             ctrl;
        isa_pkg::word_t    pc_plus4;
        isa_pkg::word_t    op_a;
        isa_pkg::word_t    op_b;
        // sign-extended imm16
        isa_pkg::word_t    imm;
        isa_pkg::reg_idx_t rs1;
        isa_pkg::reg_idx_t rs2;
        isa_pkg::reg_idx_t rd;
    } id_ex_t;

    typedef struct packed {
        ctrl_t             ctrl;
        isa_pkg::word_t    alu_result;
        isa_pkg::word_t    store_data;
        isa_pkg::reg_idx_t rd;
        // kept for the store-data forward in mem
        isa_pkg::reg_idx_t rs2;
    } ex_mem_t;

    typedef struct packed {
        logic              reg_write;
        logic              mem_to_reg;
        isa_pkg::word_t    alu_result;
        isa_pkg::word_t    load_data;
        isa_pkg::reg_idx_t rd;
    } mem_wb_t;

    // data port request
    typedef struct packed {
        isa_pkg::word_t addr;
        isa_pkg::word_t wdata;
        logic           we;
    } dmem_req_t;

    typedef enum logic [0:1] {
        fwd_none,
        fwd_mem,
        fwd_wb
    } fwd_sel_t;

endpackage

//--- design/fetch_stage.sv
module fetch_stage #(
    parameter isa_pkg::word_t reset_pc = '0
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             stall,
    input  logic             redirect,
    input  isa_pkg::word_t   redirect_target,
    input  isa_pkg::word_t   imem_data,
    output isa_pkg::word_t   imem_addr,
    output pipe_pkg::if_id_t if_id
);

    isa_pkg::word_t pc;
    isa_pkg::word_t pc_plus4;

    assign pc_plus4  = pc + 32'd4;
    // instruction read is combinational on the pc
    assign imem_addr = pc;

    // redirect wins over the load-use hold
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (redirect) begin
            pc <= redirect_target;
        end else if (!stall) begin
            pc <= pc_plus4;
        end
    end

    // if/id register
    always_ff @(posedge clk) begin
        if (reset || redirect) begin
            // squashed slot
            if_id.valid <= 1'b0;
        end else if (!stall) begin
            if_id.valid    <= 1'b1;
            if_id.pc_plus4 <= pc_plus4;
            if_id.instr    <= imem_data;
        end
    end

    // branch targets from ex must keep the pc on a word boundary
    a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[30:31] == 2'b00)
        else $error("pc not word aligned");

endmodule

//--- design/register_file.sv
module register_file (
    input  logic              clk,
    input  logic              reset,
    input  isa_pkg::reg_idx_t rs1,
    input  isa_pkg::reg_idx_t rs2,
    input  logic              wb_we,
    input  isa_pkg::reg_idx_t wb_rd,
    input  isa_pkg::word_t    wb_value,
    output isa_pkg::word_t    rs1_value,
    output isa_pkg::word_t    rs2_value
);

    isa_pkg::word_t regs [0:31];
    logic           wr_en;

    // r0 is never written
    assign wr_en = wb_we && (wb_rd != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_rd] <= wb_value;
        end
    end

    // write-through so id sees the value wb writes this cycle
    assign rs1_value = (wr_en && wb_rd == rs1) ? wb_value : regs[rs1];
    assign rs2_value = (wr_en && wb_rd == rs2) ? wb_value : regs[rs2];

    a_r0_zero: assert property (@(posedge clk) disable iff (reset) regs[0] == '0)
        else $error("r0 storage changed");

endmodule

//--- design/decode_stage.sv
module decode_stage (
    input  logic              clk,
    input  logic              reset,
    input  pipe_pkg::if_id_t  if_id,
    input  isa_pkg::word_t    rs1_value,
    input  isa_pkg::word_t    rs2_value,
    input  logic              stall,
    input  logic              squash,
    output isa_pkg::reg_idx_t rs1,
    output isa_pkg::reg_idx_t rs2,
    output logic              id_uses_rs2_as_data,
    output pipe_pkg::id_ex_t  id_ex
);

    isa_pkg::word_t    instr;
    isa_pkg::opcode_t  opcode;
    isa_pkg::func_t    func;
    pipe_pkg::ctrl_t   ctrl;
    isa_pkg::reg_idx_t rd;
    isa_pkg::word_t    imm;
    logic              reads_rs2;

    assign instr  = if_id.instr;
    assign opcode = isa_pkg::opcode_t'(instr[isa_pkg::opcode_pos +: 6]);
    assign func   = isa_pkg::func_t'(instr[isa_pkg::func_pos +: 6]);
    // sign bit is the msb of imm16
    assign imm    = {{16{instr[isa_pkg::imm16_pos]}}, instr[isa_pkg::imm16_pos +: 16]};

    // control decode, unknown opcodes fall through as a bubble
    always_comb begin
        ctrl      = '0;
        rd        = '0;
        reads_rs2 = 1'b0;
        case (opcode)
            isa_pkg::op_rtype: begin
                ctrl.reg_write = 1'b1;
                rd             = instr[isa_pkg::rd_pos +: 5];
                reads_rs2      = 1'b1;
                case (func)
                    isa_pkg::func_add: ctrl.alu_op = isa_pkg::alu_add;
                    isa_pkg::func_sub: ctrl.alu_op = isa_pkg::alu_sub;
                    isa_pkg::func_and: ctrl.alu_op = isa_pkg::alu_and;
                    isa_pkg::func_or:  ctrl.alu_op = isa_pkg::alu_or;
                    isa_pkg::func_xor: ctrl.alu_op = isa_pkg::alu_xor;
                    isa_pkg::func_slt: ctrl.alu_op = isa_pkg::alu_slt;
                    isa_pkg::func_sll: ctrl.alu_op = isa_pkg::alu_sll;
                    isa_pkg::func_srl: ctrl.alu_op = isa_pkg::alu_srl;
                    // unknown function code
                    default:           ctrl.reg_write = 1'b0;
                endcase
            end
            isa_pkg::op_addi: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                rd               = instr[isa_pkg::itype_rd_pos +: 5];
            end
            isa_pkg::op_lw: begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                rd               = instr[isa_pkg::itype_rd_pos +: 5];
            end
            isa_pkg::op_sw: begin
                // address from rs1 + imm, data from rs2
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                reads_rs2        = 1'b1;
            end
            isa_pkg::op_beqz: begin
                ctrl.branch         = 1'b1;
                ctrl.branch_on_zero = 1'b1;
            end
            isa_pkg::op_bnez: ctrl.branch = 1'b1;
            default: ;
        endcase
    end

    // rs2 reads as r0 when the field is a destination
    assign rs1 = instr[isa_pkg::rs1_pos +: 5];
    assign rs2 = reads_rs2 ? instr[isa_pkg::rs2_pos +: 5] : '0;
    assign id_uses_rs2_as_data = ctrl.mem_write;

    // id/ex register
    always_ff @(posedge clk) begin
        if (reset || squash || stall || !if_id.valid) begin
            id_ex.valid <= 1'b0;
            id_ex.ctrl  <= '0;
        end else begin
            id_ex.valid    <= 1'b1;
            id_ex.ctrl     <= ctrl;
            id_ex.pc_plus4 <= if_id.pc_plus4;
            id_ex.op_a     <= rs1_value;
            id_ex.op_b     <= rs2_value;
            id_ex.imm      <= imm;
            id_ex.rs1      <= rs1;
            id_ex.rs2      <= rs2;
            id_ex.rd       <= rd;
        end
    end

endmodule

//--- design/hazard_unit.sv
module hazard_unit (
    input  isa_pkg::reg_idx_t  id_rs1,
    input  isa_pkg::reg_idx_t  id_rs2,
    input  logic               id_uses_rs2_as_data,
    input  logic               ex_is_load,
    input  isa_pkg::reg_idx_t  ex_rd,
    input  isa_pkg::reg_idx_t  ex_rs1,
    input  isa_pkg::reg_idx_t  ex_rs2,
    input  logic               mem_reg_write,
    input  isa_pkg::reg_idx_t  mem_rd,
    input  logic               wb_we,
    input  isa_pkg::reg_idx_t  wb_rd,
    input  isa_pkg::reg_idx_t  mem_store_rs2,
    input  logic               mem_is_store,
    output pipe_pkg::fwd_sel_t fwd_a,
    output pipe_pkg::fwd_sel_t fwd_b,
    output logic               store_fwd,
    output logic               stall
);

    // forward source for one ex operand, mem before wb
    function automatic pipe_pkg::fwd_sel_t fwd_for(input isa_pkg::reg_idx_t src);
        if (src == '0) begin
            return pipe_pkg::fwd_none;
        end
        if (mem_reg_write && mem_rd == src) begin
            return pipe_pkg::fwd_mem;
        end
        if (wb_we && wb_rd == src) begin
            return pipe_pkg::fwd_wb;
        end
        return pipe_pkg::fwd_none;
    endfunction

    always_comb begin
        fwd_a = fwd_for(ex_rs1);
        fwd_b = fwd_for(ex_rs2);
    end

    // load in ex feeding an id operand
    // store data is left to the wb to mem forward
    assign stall = ex_is_load && (ex_rd != '0) &&
                   ((ex_rd == id_rs1) || ((ex_rd == id_rs2) && !id_uses_rs2_as_data));

    // store in mem whose data register is being written back
    assign store_fwd = mem_is_store && wb_we && (wb_rd != '0) && (wb_rd == mem_store_rs2);

endmodule

//--- design/execute_stage.sv
module execute_stage (
    input  logic               clk,
    input  logic               reset,
    input  pipe_pkg::id_ex_t   id_ex,
    input  pipe_pkg::fwd_sel_t fwd_a,
    input  pipe_pkg::fwd_sel_t fwd_b,
    input  isa_pkg::word_t     mem_result,
    input  isa_pkg::word_t     wb_value,
    output logic               redirect,
    output isa_pkg::word_t     redirect_target,
    output pipe_pkg::ex_mem_t  ex_mem
);

    isa_pkg::word_t op_a;
    isa_pkg::word_t op_b;
    isa_pkg::word_t alu_b;
    isa_pkg::word_t alu_result;
    logic           a_is_zero;

    ////////////////////////////////////////////////////////////////////////////
    // operand forwarding
    ////////////////////////////////////////////////////////////////////////////

    function automatic isa_pkg::word_t forward(input pipe_pkg::fwd_sel_t sel,
                                               input isa_pkg::word_t reg_value);
        case (sel)
            pipe_pkg::fwd_mem: return mem_result;
            pipe_pkg::fwd_wb:  return wb_value;
            default:           return reg_value;
        endcase
    endfunction

    always_comb begin
        op_a = forward(fwd_a, id_ex.op_a);
        op_b = forward(fwd_b, id_ex.op_b);
    end

    // immediate replaces rs2 for addi, lw, sw
    assign alu_b      = id_ex.ctrl.alu_src_imm ? id_ex.imm : op_b;
    assign alu_result = isa_pkg::alu_compute(id_ex.ctrl.alu_op, op_a, alu_b);

    ////////////////////////////////////////////////////////////////////////////
    // branch resolution
    ////////////////////////////////////////////////////////////////////////////

    // beqz taken on zero, bnez on non-zero
    assign a_is_zero       = (op_a == '0);
    assign redirect        = id_ex.valid && id_ex.ctrl.branch &&
                             (a_is_zero == id_ex.ctrl.branch_on_zero);
    assign redirect_target = id_ex.pc_plus4 + id_ex.imm;

    // ex/mem register
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mem.ctrl <= '0;
        end else begin
            ex_mem.ctrl       <= id_ex.ctrl;
            ex_mem.alu_result <= alu_result;
            // forwarded rs2 is the store data
            ex_mem.store_data <= op_b;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.rs2        <= id_ex.rs2;
        end
    end

    // a load in mem has no data yet, only its address
    a_no_load_fwd: assert property (@(posedge clk) disable iff (reset)
        ex_mem.ctrl.mem_to_reg |-> (fwd_a != pipe_pkg::fwd_mem && fwd_b != pipe_pkg::fwd_mem))
        else $error("mem forward selected from a load");

endmodule

//--- design/memory_writeback.sv
module memory_writeback (
    input  logic                clk,
    input  logic                reset,
    input  pipe_pkg::ex_mem_t   ex_mem,
    input  logic                store_fwd,
    input  isa_pkg::word_t      dmem_rdata,
    output pipe_pkg::dmem_req_t dmem_req,
    output isa_pkg::word_t      mem_result,
    output logic                wb_we,
    output isa_pkg::reg_idx_t   wb_rd,
    output isa_pkg::word_t      wb_value
);

    pipe_pkg::mem_wb_t mem_wb;

    // data port, store data may come straight from wb
    assign dmem_req.addr  = ex_mem.alu_result;
    assign dmem_req.wdata = store_fwd ? wb_value : ex_mem.store_data;
    assign dmem_req.we    = ex_mem.ctrl.mem_write;
    // mem to ex forward value
    assign mem_result     = ex_mem.alu_result;

    // mem/wb register
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_wb.reg_write  <= 1'b0;
            mem_wb.mem_to_reg <= 1'b0;
        end else begin
            mem_wb.reg_write  <= ex_mem.ctrl.reg_write;
            mem_wb.mem_to_reg <= ex_mem.ctrl.mem_to_reg;
            mem_wb.alu_result <= ex_mem.alu_result;
            mem_wb.load_data  <= dmem_rdata;
            mem_wb.rd         <= ex_mem.rd;
        end
    end

    // writeback select
    assign wb_we    = mem_wb.reg_write;
    assign wb_rd    = mem_wb.rd;
    assign wb_value = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

endmodule

//--- design/pipeline_cpu.sv
module pipeline_cpu #(
    parameter isa_pkg::word_t reset_pc = '0
) (
    input  logic                clk,
    input  logic                reset,
    output isa_pkg::word_t      imem_addr,
    input  isa_pkg::word_t      imem_data,
    output pipe_pkg::dmem_req_t dmem_req,
    input  isa_pkg::word_t      dmem_rdata
);

    ////////////////////////////////////////////////////////////////////////////
    // stage registers and cross-stage nets
    ////////////////////////////////////////////////////////////////////////////

    pipe_pkg::if_id_t   if_id;
    pipe_pkg::id_ex_t   id_ex;
    pipe_pkg::ex_mem_t  ex_mem;

    isa_pkg::reg_idx_t  rs1;
    isa_pkg::reg_idx_t  rs2;
    isa_pkg::word_t     rs1_value;
    isa_pkg::word_t     rs2_value;
    logic               id_uses_rs2_as_data;

    pipe_pkg::fwd_sel_t fwd_a;
    pipe_pkg::fwd_sel_t fwd_b;
    logic               store_fwd;
    logic               stall;

    logic               redirect;
    isa_pkg::word_t     redirect_target;
    isa_pkg::word_t     mem_result;
    logic               wb_we;
    isa_pkg::reg_idx_t  wb_rd;
    isa_pkg::word_t     wb_value;

    ////////////////////////////////////////////////////////////////////////////
    // pipeline stages
    ////////////////////////////////////////////////////////////////////////////

    fetch_stage #(.reset_pc(reset_pc)) if_stage (
        .clk(clk), .reset(reset), .stall(stall), .redirect(redirect),
        .redirect_target(redirect_target), .imem_data(imem_data),
        .imem_addr(imem_addr), .if_id(if_id)
    );

    // taken branch in ex squashes the id slot as well
    decode_stage id_stage (
        .clk(clk), .reset(reset), .if_id(if_id),
        .rs1_value(rs1_value), .rs2_value(rs2_value),
        .stall(stall), .squash(redirect),
        .rs1(rs1), .rs2(rs2), .id_uses_rs2_as_data(id_uses_rs2_as_data),
        .id_ex(id_ex)
    );

    register_file reg_file (
        .clk(clk), .reset(reset), .rs1(rs1), .rs2(rs2),
        .wb_we(wb_we), .wb_rd(wb_rd), .wb_value(wb_value),
        .rs1_value(rs1_value), .rs2_value(rs2_value)
    );

    execute_stage ex_stage (
        .clk(clk), .reset(reset), .id_ex(id_ex), .fwd_a(fwd_a), .fwd_b(fwd_b),
        .mem_result(mem_result), .wb_value(wb_value),
        .redirect(redirect), .redirect_target(redirect_target), .ex_mem(ex_mem)
    );

    memory_writeback mem_wb_stage (
        .clk(clk), .reset(reset), .ex_mem(ex_mem), .store_fwd(store_fwd),
        .dmem_rdata(dmem_rdata), .dmem_req(dmem_req), .mem_result(mem_result),
        .wb_we(wb_we), .wb_rd(wb_rd), .wb_value(wb_value)
    );

    // loads in mem only forward once their data reaches wb
    hazard_unit hazard (
        .id_rs1(rs1), .id_rs2(rs2), .id_uses_rs2_as_data(id_uses_rs2_as_data),
        .ex_is_load(id_ex.ctrl.mem_to_reg), .ex_rd(id_ex.rd),
        .ex_rs1(id_ex.rs1), .ex_rs2(id_ex.rs2),
        .mem_reg_write(ex_mem.ctrl.reg_write && !ex_mem.ctrl.mem_to_reg),
        .mem_rd(ex_mem.rd), .wb_we(wb_we), .wb_rd(wb_rd),
        .mem_store_rs2(ex_mem.rs2), .mem_is_store(ex_mem.ctrl.mem_write),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .store_fwd(store_fwd), .stall(stall)
    );

endmodule

//--- testbench/tb_pipeline_cpu.sv
module tb_pipeline_cpu;

    timeunit 1ns;
    timeprecision 100ps;

    localparam isa_pkg::word_t reset_pc = '0;
    localparam int mem_words = 64;
    // dynamic instruction budget of the program, shared by model and run limit
    localparam int max_dyn_instr    = 60;
    localparam int cycles_per_instr = 4;
    localparam int timeout_cycles   = max_dyn_instr * cycles_per_instr + 160;

    logic                clk;
    logic                reset;
    isa_pkg::word_t      imem_addr;
    isa_pkg::word_t      imem_data;
    pipe_pkg::dmem_req_t dmem_req;
    isa_pkg::word_t      dmem_rdata;

    // port words seen as plain [31:0] vectors
    logic [31:0] fetch_addr;
    logic [31:0] d_addr;
    logic [31:0] d_wdata;
    logic        d_we;

    logic [31:0] imem [0:mem_words-1];
    logic [31:0] dmem [0:mem_words-1];
    logic [31:0] model_regs [0:31];
    logic [31:0] model_mem [0:mem_words-1];
    // stores of the model, in program order
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] halt_addr;
    logic [31:0] last_fetch = '1;

    integer seed;
    int     store_idx = 0;
    int     halt_hits = 0;
    int     cycles_out_of_reset = 0;
    int     cycle_count = 0;

    pipeline_cpu #(.reset_pc(reset_pc)) UUT (
        .clk(clk), .reset(reset), .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_req(dmem_req), .dmem_rdata(dmem_rdata)
    );

    ////////////////////////////////////////////////////////////////////////////
    // memories
    ////////////////////////////////////////////////////////////////////////////

    assign fetch_addr = imem_addr;
    assign d_addr     = dmem_req.addr;
    assign d_wdata    = dmem_req.wdata;
    assign d_we       = dmem_req.we;

    // both ports read combinationally, word index from the byte address
    assign imem_data  = imem[fetch_addr[7:2]];
    assign dmem_rdata = dmem[d_addr[7:2]];

    always @(posedge clk) begin
        if (d_we) begin
            dmem[d_addr[7:2]] <= d_wdata;
        end
    end

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // failure reporting
    ////////////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("FAILED at %0t ns: %s expected 0x%08h, actual 0x%08h",
                 $time, name, expected, actual);
        $display("test failed");
        $fatal(1, "%s mismatch", name);
    endtask

    task automatic fail_run(input string reason);
        $display("ERROR at %0t ns: %s", $time, reason);
        $display("test failed");
        $fatal(1, "%s", reason);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // instruction-level reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] model_alu(input logic [5:0] func, input logic [31:0] a,
                                              input logic [31:0] b);
        case (func)
            isa_pkg::func_add: return a + b;
            isa_pkg::func_sub: return a - b;
            isa_pkg::func_and: return a & b;
            isa_pkg::func_or:  return a | b;
            isa_pkg::func_xor: return a ^ b;
            isa_pkg::func_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            // shift by the low five bits of rs2
            isa_pkg::func_sll: return a << b[4:0];
            isa_pkg::func_srl: return a >> b[4:0];
            default:           return a;
        endcase
    endfunction

    task automatic run_reference_model();
        logic [31:0] pc;
        logic [31:0] ir;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] ea;
        logic [31:0] next_pc;
        logic [5:0]  op;
        logic        taken;
        bit          halted;
        halted = 1'b0;
        pc     = reset_pc;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        for (int n = 0; n < max_dyn_instr && !halted; n++) begin
            ir      = imem[pc[7:2]];
            op      = ir[31:26];
            a       = model_regs[ir[25:21]];
            b       = model_regs[ir[20:16]];
            imm     = {{16{ir[15]}}, ir[15:0]};
            ea      = a + imm;
            next_pc = pc + 32'd4;
            case (op)
                isa_pkg::op_rtype: model_regs[ir[15:11]] = model_alu(ir[5:0], a, b);
                // i-type destination sits in the rs2 field
                isa_pkg::op_addi:  model_regs[ir[20:16]] = ea;
                isa_pkg::op_lw:    model_regs[ir[20:16]] = model_mem[ea[7:2]];
                isa_pkg::op_sw: begin
                    exp_addr.push_back(ea);
                    exp_data.push_back(b);
                    model_mem[ea[7:2]] = b;
                end
                isa_pkg::op_beqz, isa_pkg::op_bnez: begin
                    taken = ((a == '0) == (op == isa_pkg::op_beqz));
                    if (taken) begin
                        next_pc = pc + 32'd4 + imm;
                    end
                    // branch onto itself ends the program
                    if (taken && next_pc == pc) begin
                        halted    = 1'b1;
                        halt_addr = pc;
                    end
                end
                default: ;
            endcase
            model_regs[0] = '0;
            pc = next_pc;
        end
        if (!halted) begin
            fail_run("reference model never reached the halt branch");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // port checks, mid-cycle when the ports are settled
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (reset) begin
            assert (!d_we) else report_mismatch("dmem_req.we", 32'd0, {31'd0, d_we});
        end else begin
            // first cycle out of reset
            if (cycles_out_of_reset == 0) begin
                assert (!d_we) else report_mismatch("dmem_req.we", 32'd0, {31'd0, d_we});
                assert (fetch_addr == reset_pc)
                    else report_mismatch("imem_addr", reset_pc, fetch_addr);
            end
            cycles_out_of_reset++;
            if (d_we) begin
                assert (halt_hits < 2) else fail_run("store seen after the halt was refetched");
                // squashed wrong-path sw lands here or in the address compare
                assert (store_idx < exp_addr.size())
                    else fail_run("store beyond the reference model's list");
                assert (d_addr == exp_addr[store_idx])
                    else report_mismatch("dmem_req.addr", exp_addr[store_idx], d_addr);
                assert (d_wdata == exp_data[store_idx])
                    else report_mismatch("dmem_req.wdata", exp_data[store_idx], d_wdata);
                store_idx++;
            end
            // count arrivals at the halt address, not cycles spent there
            if (fetch_addr == halt_addr && last_fetch != halt_addr) begin
                halt_hits++;
                if (halt_hits == 2) begin
                    assert (store_idx == exp_addr.size())
                        else fail_run("halt refetched before all model stores were seen");
                end
            end
            last_fetch = fetch_addr;
        end
    end

    // run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            fail_run($sformatf("timeout after %0d cycles without a halt", cycle_count));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        reset = 1'b1;
        seed  = 32'h398e_02f2;
        $readmemh("testbench/program.hex", imem);
        for (int i = 0; i < mem_words; i++) begin
            dmem[i]      = $random(seed);
            model_mem[i] = dmem[i];
        end
        run_reference_model();
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        wait (halt_hits >= 2);
        // trailing cycles, any store now is an error
        repeat (8) @(posedge clk);
        if (store_idx == exp_addr.size()) begin
            $display("test passed");
            $finish;
        end else begin
            fail_run("not every reference model store was seen");
        end
    end

endmodule

//--- testbench/program.hex
// one 32-bit instruction per line in hex, line n holds byte address 4*n
// text after the word is the assembly form
2002000C  // 0x00 addi r2, r0, 12
20430005  // 0x04 addi r3, r2, 5      mem forward
00622020  // 0x08 add  r4, r3, r2     mem and wb forward
00822804  // 0x0C sll  r5, r4, r2
00A33026  // 0x10 xor  r6, r5, r3
AC460000  // 0x14 sw   r6, 0(r2)      r-type result stored next
8C010028  // 0x18 lw   r1, 40(r0)
0023382A  // 0x1C slt  r7, r1, r3     load-use on rs1
8C08002C  // 0x20 lw   r8, 44(r0)
00484825  // 0x24 or   r9, r2, r8     load-use on rs2
01265824  // 0x28 and  r11, r9, r6
AC0B0010  // 0x2C sw   r11, 16(r0)
8C0A0030  // 0x30 lw   r10, 48(r0)
AC0A0014  // 0x34 sw   r10, 20(r0)    loaded value stored, wb to mem
01436006  // 0x38 srl  r12, r10, r3
14400008  // 0x3C bnez r2, +8         taken
AC07001C  // 0x40 sw   r7, 28(r0)     squashed
AC0C0020  // 0x44 sw   r12, 32(r0)    squashed
10600008  // 0x48 beqz r3, +8         not taken
AC070018  // 0x4C sw   r7, 24(r0)
AC0C0020  // 0x50 sw   r12, 32(r0)
1000FFFC  // 0x54 beqz r0, -4         halt

//--- build.f
design/isa_pkg.sv
design/pipe_pkg.sv
design/fetch_stage.sv
design/register_file.sv
design/decode_stage.sv
design/hazard_unit.sv
design/execute_stage.sv
design/memory_writeback.sv
design/pipeline_cpu.sv
testbench/tb_pipeline_cpu.sv

//--- Makefile
VERILATOR  = verilator
TOP        = tb_pipeline_cpu
FILELIST   = build.f
OBJ_DIR    = obj_dir
COMMON     = --timing --timescale 1ns/100ps --top-module $(TOP)
LINT_FLAGS = --lint-only $(COMMON)
SIM_FLAGS  = --binary --assert -Wno-fatal --Mdir $(OBJ_DIR) $(COMMON)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

# the binary exits non-zero on $fatal, so make fails with the test
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
